/* verilog/boxcar_pkg.sv */
`default_nettype none

package boxcar_pkg;

    localparam int SAMPLE_W = 12;
    localparam int WIN_N    = 16;
    localparam int WIN_AW   = 4;
    localparam int SUM_W    = SAMPLE_W + WIN_AW;  // worst case fits without overflow
    localparam int WORD_W   = 32;
    localparam int APB_AW   = 8;

    typedef logic signed [SAMPLE_W-1:0] sample_t;
    typedef logic signed [SUM_W-1:0]    sum_t;
    typedef logic [WIN_AW-1:0]          win_addr_t;
    typedef logic [WORD_W-1:0]          word_t;
    typedef logic [APB_AW-1:0]          apb_addr_t;

    // register map
    localparam apb_addr_t REG_CTRL  = 8'h00;
    localparam apb_addr_t REG_COUNT = 8'h04;
    localparam apb_addr_t REG_SUM   = 8'h08;
    localparam apb_addr_t REG_WIN   = 8'h0C;

    localparam int CTRL_EN_BIT  = 0;
    localparam int CTRL_CLR_BIT = 1;  // write-only, self-clearing

    typedef struct packed {
        logic      psel;
        logic      penable;
        logic      pwrite;
        apb_addr_t paddr;
        word_t     pwdata;
    } apb_req_t;

    typedef struct packed {
        word_t prdata;
        logic  pready;
        logic  pslverr;
    } apb_rsp_t;

endpackage

`default_nettype wire

/* verilog/sdp_ram.sv */
`timescale 1ns/1ps
`default_nettype none

module sdp_ram #(
    parameter int width = 8,
    parameter int depth = 16
)(
    input  wire                       clk,
    input  wire                       resetn,

    // write port
    input  wire                       wen_i,
    input  wire [$clog2(depth)-1:0]   waddr_i,
    input  wire [width-1:0]           wdata_i,

    // read port, one cycle latency
    input  wire                       ren_i,
    input  wire [$clog2(depth)-1:0]   raddr_i,
    output logic [width-1:0]          rdata_o
);

    logic [width-1:0] mem [depth];
    logic [width-1:0] rdata_q;

    always_ff @(posedge clk)
    begin
        if (wen_i)
        begin
            mem[waddr_i] <= wdata_i;
        end
    end

    // read-during-write returns the old contents
    always_ff @(posedge clk or negedge resetn)
    begin
        if (!resetn)
        begin
            rdata_q <= '0;
        end
        else if (ren_i)
        begin
            rdata_q <= mem[raddr_i];
        end
    end

    assign rdata_o = rdata_q;

endmodule

`default_nettype wire

/* verilog/ram_shift_reg.sv */
`timescale 1ns/1ps
`default_nettype none

module ram_shift_reg #(
    parameter int data_width = 8,
    parameter int depth      = 16  // power of two
)(
    input  wire                     clk,
    input  wire                     resetn,

    input  wire                     advance_i,
    input  wire [data_width-1:0]    shift_in_i,
    output logic [data_width-1:0]   shift_out_o
);

    localparam int aw = $clog2(depth);

    logic [aw-1:0] waddr_q;
    logic [aw-1:0] raddr_q;

    // write pointer sits one slot behind the read pointer, so each read
    // picks up the oldest entry still in the ring
    always_ff @(posedge clk or negedge resetn)
    begin
        if (!resetn)
        begin
            waddr_q <= aw'(depth - 1);
        end
        else if (advance_i)
        begin
            waddr_q <= (waddr_q == aw'(depth - 1)) ? '0 : waddr_q + 1'b1;
        end
    end

    always_ff @(posedge clk or negedge resetn)
    begin
        if (!resetn)
        begin
            raddr_q <= '0;
        end
        else if (advance_i)
        begin
            raddr_q <= (raddr_q == aw'(depth - 1)) ? '0 : raddr_q + 1'b1;
        end
    end

    sdp_ram #(
        .width (data_width),
        .depth (depth)
    ) u_ram (
        .clk     (clk),
        .resetn  (resetn),
        .wen_i   (advance_i),
        .waddr_i (waddr_q),
        .wdata_i (shift_in_i),
        .ren_i   (advance_i),    // read register holds between advances
        .raddr_i (raddr_q),
        .rdata_o (shift_out_o)
    );

endmodule

`default_nettype wire

/* verilog/moving_sum.sv */
`timescale 1ns/1ps
`default_nettype none

module moving_sum
    import boxcar_pkg::*;
(
    input  wire           clk,
    input  wire           resetn,

    input  wire           enable_i,
    input  wire           clear_i,

    input  wire sample_t  sample_i,
    input  wire           valid_i,

    // delay line side
    output logic          advance_o,
    output sample_t       sample_o,
    input  wire sample_t  delayed_i,

    output sum_t          sum_o,
    output logic          sum_valid_o
);

    logic      accept;
    win_addr_t fill_cnt;
    logic      full;        // window holds WIN_N samples
    sample_t   delayed_m;
    sum_t      acc_q;
    logic      valid_q;

    assign accept    = valid_i & enable_i & ~clear_i;  // clear wins over a sample
    assign advance_o = accept;
    assign sample_o  = sample_i;

    // RAM contents are stale until the window has refilled
    assign delayed_m = full ? delayed_i : '0;

    always_ff @(posedge clk or negedge resetn)
    begin
        if (!resetn)
        begin
            fill_cnt <= '0;
            full     <= 1'b0;
        end
        else if (clear_i)
        begin
            fill_cnt <= '0;
            full     <= 1'b0;
        end
        else if (accept && !full)
        begin
            fill_cnt <= fill_cnt + 1'b1;
            if (fill_cnt == win_addr_t'(WIN_N - 1))
            begin
                full <= 1'b1;  // saturates here
            end
        end
    end

    always_ff @(posedge clk or negedge resetn)
    begin
        if (!resetn)
        begin
            acc_q   <= '0;
            valid_q <= 1'b0;
        end
        else
        begin
            valid_q <= accept;
            if (clear_i)
            begin
                acc_q <= '0;
            end
            else if (accept)
            begin
                acc_q <= acc_q + sum_t'(sample_i) - sum_t'(delayed_m);
            end
        end
    end

    assign sum_o       = acc_q;
    assign sum_valid_o = valid_q;

endmodule

`default_nettype wire

/* verilog/apb_ctrl_regs.sv */
`timescale 1ns/1ps
`default_nettype none

module apb_ctrl_regs
    import boxcar_pkg::*;
(
    input  wire            clk,
    input  wire            resetn,

    input  wire apb_req_t  apb_req_i,
    output apb_rsp_t       apb_rsp_o,

    output logic           enable_o,
    output logic           clear_o,

    input  wire sum_t      sum_i,
    input  wire            sum_valid_i
);

    logic  access;
    logic  addr_hit;
    logic  ctrl_wr;
    logic  bad_access;
    logic  enable_q;
    logic  clear_q;
    word_t count_q;
    sum_t  sum_q;
    word_t rdata;

    assign access   = apb_req_i.psel & apb_req_i.penable;
    assign addr_hit = apb_req_i.paddr inside {REG_CTRL, REG_COUNT, REG_SUM, REG_WIN};
    assign ctrl_wr  = access & apb_req_i.pwrite & (apb_req_i.paddr == REG_CTRL);

    // unmapped offsets and writes to status registers
    assign bad_access = access & (~addr_hit |
                        (apb_req_i.pwrite & (apb_req_i.paddr != REG_CTRL)));

    always_ff @(posedge clk or negedge resetn)
    begin
        if (!resetn)
        begin
            enable_q <= 1'b0;
            clear_q  <= 1'b0;
        end
        else
        begin
            clear_q <= ctrl_wr & apb_req_i.pwdata[CTRL_CLR_BIT];  // one cycle only
            if (ctrl_wr)
            begin
                enable_q <= apb_req_i.pwdata[CTRL_EN_BIT];
            end
        end
    end

    always_ff @(posedge clk or negedge resetn)
    begin
        if (!resetn)
        begin
            count_q <= '0;
            sum_q   <= '0;
        end
        else if (clear_q)
        begin
            count_q <= '0;
            sum_q   <= '0;
        end
        else if (sum_valid_i)
        begin
            count_q <= count_q + 1'b1;
            sum_q   <= sum_i;
        end
    end

    always_comb
    begin
        case (apb_req_i.paddr)
            REG_CTRL:  rdata = word_t'(enable_q);  // clear bit reads as zero
            REG_COUNT: rdata = count_q;
            REG_SUM:   rdata = {{(WORD_W - SUM_W){sum_q[SUM_W-1]}}, sum_q};
            REG_WIN:   rdata = word_t'(WIN_N);
            default:   rdata = '0;
        endcase
    end

    always_comb
    begin
        apb_rsp_o.prdata  = rdata;
        apb_rsp_o.pready  = 1'b1;  // no wait states
        apb_rsp_o.pslverr = bad_access;
    end

    assign enable_o = enable_q;
    assign clear_o  = clear_q;

endmodule

`default_nettype wire

/* verilog/boxcar_top.sv */
`timescale 1ns/1ps
`default_nettype none

module boxcar_top
    import boxcar_pkg::*;
(
    input  wire            clk,
    input  wire            resetn,

    input  wire apb_req_t  apb_req_i,
    output apb_rsp_t       apb_rsp_o,

    input  wire sample_t   sample_i,
    input  wire            valid_i,

    output sum_t           sum_o,
    output logic           sum_valid_o
);

    logic    enable;
    logic    clear;
    logic    advance;
    sample_t dl_in;
    sample_t dl_out;

    apb_ctrl_regs u_regs (
        .clk         (clk),
        .resetn      (resetn),
        .apb_req_i   (apb_req_i),
        .apb_rsp_o   (apb_rsp_o),
        .enable_o    (enable),
        .clear_o     (clear),
        .sum_i       (sum_o),
        .sum_valid_i (sum_valid_o)
    );

    moving_sum u_sum (
        .clk         (clk),
        .resetn      (resetn),
        .enable_i    (enable),
        .clear_i     (clear),
        .sample_i    (sample_i),
        .valid_i     (valid_i),
        .advance_o   (advance),
        .sample_o    (dl_in),
        .delayed_i   (dl_out),
        .sum_o       (sum_o),
        .sum_valid_o (sum_valid_o)
    );

    // window delay line, WIN_N samples deep
    ram_shift_reg #(
        .data_width (SAMPLE_W),
        .depth      (WIN_N)
    ) u_delay (
        .clk         (clk),
        .resetn      (resetn),
        .advance_i   (advance),
        .shift_in_i  (dl_in),
        .shift_out_o (dl_out)
    );

endmodule

`default_nettype wire

/* verif/boxcar_props.sv */
`timescale 1ns/1ps
`default_nettype none

module boxcar_props #(
    parameter bit stream_side = 1'b1  // which half of the checks is live
)(
    input wire clk,
    input wire resetn,
    input wire enable_i,
    input wire clear_i,
    input wire accept_i,
    input wire sum_valid_i,
    input wire apb_access_i,
    input wire pready_i
);

    int fail_cnt = 0;

    // one sum per accepted sample, exactly one cycle later
    sum_after_accept: assert property (@(posedge clk) disable iff (!resetn || !stream_side)
        accept_i |=> sum_valid_i)
    else
    begin
        fail_cnt++;
        $error("sum_valid_o missing after an accepted sample");
    end

    sum_needs_accept: assert property (@(posedge clk) disable iff (!resetn || !stream_side)
        sum_valid_i |-> $past(accept_i))
    else
    begin
        fail_cnt++;
        $error("sum_valid_o high without an accepted sample");
    end

    no_sum_when_disabled: assert property (@(posedge clk) disable iff (!resetn || !stream_side)
        $rose(sum_valid_i) |-> $past(enable_i))
    else
    begin
        fail_cnt++;
        $error("sum_valid_o rose while the filter was disabled");
    end

    // zero wait states on the bus
    ready_in_access: assert property (@(posedge clk) disable iff (!resetn || stream_side)
        apb_access_i |-> pready_i)
    else
    begin
        fail_cnt++;
        $error("pready low during an access phase");
    end

    clear_single_cycle: assert property (@(posedge clk) disable iff (!resetn || stream_side)
        clear_i |=> !clear_i)
    else
    begin
        fail_cnt++;
        $error("clear_o held for two cycles");
    end

endmodule

bind moving_sum boxcar_props #(.stream_side(1'b1)) u_stream_props (
    .clk          (clk),
    .resetn       (resetn),
    .enable_i     (enable_i),
    .clear_i      (clear_i),
    .accept_i     (advance_o),
    .sum_valid_i  (sum_valid_o),
    .apb_access_i (1'b0),
    .pready_i     (1'b1)
);

bind apb_ctrl_regs boxcar_props #(.stream_side(1'b0)) u_apb_props (
    .clk          (clk),
    .resetn       (resetn),
    .enable_i     (enable_o),
    .clear_i      (clear_o),
    .accept_i     (1'b0),
    .sum_valid_i  (sum_valid_i),
    .apb_access_i (apb_req_i.psel & apb_req_i.penable),
    .pready_i     (apb_rsp_o.pready)
);

`default_nettype wire

/* verif/boxcar_checker.sv */
`timescale 1ns/1ps
`default_nettype none

module boxcar_checker
    import boxcar_pkg::*;
(
    input  wire            clk,
    input  wire            resetn,
    input  wire apb_req_t  apb_req_i,
    input  wire apb_rsp_t  apb_rsp_i,
    input  wire sample_t   sample_i,
    input  wire            valid_i,
    input  wire sum_t      sum_i,
    input  wire            sum_valid_i,
    output int             err_cnt_o,
    output int             sum_cnt_o
);

    int    hist[$];      // accepted samples since reset or clear
    logic  enable_m;
    logic  clear_m;      // pulse seen by the filter at the next edge
    logic  exp_valid;
    sum_t  exp_sum;
    word_t count_m;
    sum_t  sum_m;
    int    err_cnt = 0;
    int    sum_cnt = 0;

    // sum of the newest min(WIN_N, n) samples
    function automatic int window_sum();
        int s;
        int first;
        s = 0;
        first = (hist.size() > WIN_N) ? hist.size() - WIN_N : 0;
        for (int i = first; i < hist.size(); i++)
            s += hist[i];
        return s;
    endfunction

    task automatic report_mismatch(input string name, input word_t got, input word_t exp);
        $display("Error: %s = 0x%0h, expected 0x%0h at %0t", name, got, exp, $time);
        err_cnt++;
    endtask

    always @(posedge clk or negedge resetn)
    begin
        logic  access;
        logic  exp_err;
        word_t exp_rd;
        if (!resetn)
        begin
            hist.delete();
            enable_m  = 1'b0;
            clear_m   = 1'b0;
            exp_valid = 1'b0;
            exp_sum   = '0;
            count_m   = '0;
            sum_m     = '0;
        end
        else
        begin
            // outputs launched at the previous edge
            if (sum_valid_i !== exp_valid)
                report_mismatch("sum_valid_o", word_t'(sum_valid_i), word_t'(exp_valid));
            else if (exp_valid)
            begin
                sum_cnt++;
                if (sum_i !== exp_sum)
                    report_mismatch("sum_o", word_t'($unsigned(sum_i)),
                                    word_t'($unsigned(exp_sum)));
            end

            access  = apb_req_i.psel && apb_req_i.penable;
            exp_err = !(apb_req_i.paddr inside {REG_CTRL, REG_COUNT, REG_SUM, REG_WIN}) ||
                      (apb_req_i.pwrite && apb_req_i.paddr != REG_CTRL);
            if (access && apb_rsp_i.pslverr !== exp_err)
                report_mismatch("pslverr", word_t'(apb_rsp_i.pslverr), word_t'(exp_err));
            if (access && !apb_req_i.pwrite && !exp_err)
            begin
                case (apb_req_i.paddr)
                    REG_CTRL:  exp_rd = word_t'(enable_m);
                    REG_COUNT: exp_rd = count_m;
                    REG_SUM:   exp_rd = word_t'(int'(sum_m));  // sign-extended
                    default:   exp_rd = word_t'(WIN_N);
                endcase
                if (apb_rsp_i.prdata !== exp_rd)
                    report_mismatch("prdata", apb_rsp_i.prdata, exp_rd);
            end

            // clear beats both the status update and a new sample
            if (clear_m)
            begin
                hist.delete();
                count_m = '0;
                sum_m   = '0;
            end
            else if (exp_valid)
            begin
                count_m = count_m + 1;
                sum_m   = exp_sum;
            end

            exp_valid = valid_i && enable_m && !clear_m;
            if (exp_valid)
            begin
                hist.push_back(int'(sample_i));
                exp_sum = sum_t'(window_sum());
            end

            clear_m = 1'b0;
            if (access && apb_req_i.pwrite && apb_req_i.paddr == REG_CTRL)
            begin
                enable_m = apb_req_i.pwdata[CTRL_EN_BIT];
                clear_m  = apb_req_i.pwdata[CTRL_CLR_BIT];
            end
        end
    end

    assign err_cnt_o = err_cnt;
    assign sum_cnt_o = sum_cnt;

endmodule

`default_nettype wire

/* verif/boxcar_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module boxcar_tb
    import boxcar_pkg::*;
();

    localparam int CLK_PERIOD   = 40;
    localparam int DRIVE_DLY    = 2;
    localparam int RESET_CYCLES = 16;
    localparam int SEED         = 44877;
    localparam int MAX_GAP      = 3;
    localparam int N_FILL       = 10;
    localparam int N_STEADY     = 200;
    localparam int N_OFF        = 12;
    localparam int N_RESUME     = 30;
    localparam int N_CLEAR      = 40;
    localparam int N_REFILL     = 20;
    localparam int N_APB        = 32;
    localparam int N_SAMPLES    = N_FILL + 2 * N_STEADY + N_OFF + N_RESUME + N_CLEAR + N_REFILL;
    // worst case gaps on every sample, bus transfers counted at three cycles
    localparam int WATCHDOG_CYCLES = RESET_CYCLES + N_SAMPLES * (MAX_GAP + 1) + N_APB * 3 + 100;

    logic     clk;
    logic     resetn;
    apb_req_t apb_req;
    apb_rsp_t apb_rsp;
    sample_t  sample;
    logic     valid;
    sum_t     sum_out;
    logic     sum_valid;
    int       err_cnt;
    int       sum_cnt;
    int       assert_cnt;

    always #(CLK_PERIOD / 2) clk = ~clk;

    boxcar_top DUT (
        .clk         (clk),
        .resetn      (resetn),
        .apb_req_i   (apb_req),
        .apb_rsp_o   (apb_rsp),
        .sample_i    (sample),
        .valid_i     (valid),
        .sum_o       (sum_out),
        .sum_valid_o (sum_valid)
    );

    boxcar_checker u_check (
        .clk         (clk),
        .resetn      (resetn),
        .apb_req_i   (apb_req),
        .apb_rsp_i   (apb_rsp),
        .sample_i    (sample),
        .valid_i     (valid),
        .sum_i       (sum_out),
        .sum_valid_i (sum_valid),
        .err_cnt_o   (err_cnt),
        .sum_cnt_o   (sum_cnt)
    );

    task automatic next_cycle();
        @(posedge clk);
        #DRIVE_DLY;
    endtask

    // setup phase then access phase, no wait states
    task automatic apb_xfer(input logic write, input apb_addr_t addr, input word_t data);
        apb_req.psel    = 1'b1;
        apb_req.penable = 1'b0;
        apb_req.pwrite  = write;
        apb_req.paddr   = addr;
        apb_req.pwdata  = data;
        next_cycle();
        apb_req.penable = 1'b1;
        next_cycle();
        apb_req = '0;
    endtask

    function automatic sample_t pick_sample(input bit extremes);
        int r;
        r = $urandom_range(0, 9);
        if (extremes && r == 0)
            return sample_t'(-(1 << (SAMPLE_W - 1)));
        if (extremes && r == 1)
            return sample_t'((1 << (SAMPLE_W - 1)) - 1);
        return sample_t'($urandom);
    endfunction

    task automatic stream_samples(input int n, input bit gaps, input bit extremes);
        int idle;
        for (int i = 0; i < n; i++)
        begin
            idle = gaps ? $urandom_range(0, MAX_GAP) : 0;
            repeat (idle)
            begin
                valid  = 1'b0;
                sample = sample_t'($urandom);  // junk on the bus while idle
                next_cycle();
            end
            valid  = 1'b1;
            sample = pick_sample(extremes);
            next_cycle();
        end
        valid = 1'b0;
    endtask

    initial
    begin
        clk     = 1'b0;
        resetn  = 1'b0;
        apb_req = '0;
        sample  = '0;
        valid   = 1'b0;
        void'($urandom(SEED));
        repeat (RESET_CYCLES) @(posedge clk);
        #DRIVE_DLY;
        resetn = 1'b1;
        next_cycle();

        apb_xfer(1'b0, REG_WIN, '0);
        apb_xfer(1'b0, REG_CTRL, '0);
        apb_xfer(1'b0, REG_COUNT, '0);

        // partial window right after reset
        apb_xfer(1'b1, REG_CTRL, 32'h1);
        stream_samples(N_FILL, 1'b0, 1'b0);
        next_cycle();
        apb_xfer(1'b0, REG_COUNT, '0);
        apb_xfer(1'b0, REG_SUM, '0);

        // long runs, several wraps of the delay line
        stream_samples(N_STEADY, 1'b0, 1'b1);
        stream_samples(N_STEADY, 1'b1, 1'b1);
        next_cycle();
        apb_xfer(1'b0, REG_COUNT, '0);
        apb_xfer(1'b0, REG_SUM, '0);

        apb_xfer(1'b1, REG_CTRL, 32'h0);
        stream_samples(N_OFF, 1'b0, 1'b0);  // all dropped
        apb_xfer(1'b0, REG_COUNT, '0);
        apb_xfer(1'b1, REG_CTRL, 32'h1);
        stream_samples(N_RESUME, 1'b1, 1'b0);

        fork
            stream_samples(N_CLEAR, 1'b1, 1'b1);
            begin
                repeat (N_CLEAR) next_cycle();
                apb_xfer(1'b1, REG_CTRL, 32'h3);  // clear, stay enabled
            end
        join
        next_cycle();
        apb_xfer(1'b0, REG_COUNT, '0);
        apb_xfer(1'b0, REG_SUM, '0);

        // RAM still holds old samples here
        apb_xfer(1'b1, REG_CTRL, 32'h3);
        stream_samples(N_REFILL, 1'b0, 1'b1);
        next_cycle();
        apb_xfer(1'b0, REG_COUNT, '0);

        apb_xfer(1'b1, REG_COUNT, 32'hdead_beef);
        apb_xfer(1'b1, REG_SUM, 32'h1234_5678);
        apb_xfer(1'b1, REG_WIN, 32'h0);
        apb_xfer(1'b1, 8'h10, 32'h0);
        apb_xfer(1'b0, 8'h14, '0);
        apb_xfer(1'b0, REG_COUNT, '0);
        apb_xfer(1'b0, REG_SUM, '0);
        apb_xfer(1'b0, REG_WIN, '0);
        apb_xfer(1'b0, REG_CTRL, '0);
        repeat (4) next_cycle();

        assert_cnt = DUT.u_sum.u_stream_props.fail_cnt + DUT.u_regs.u_apb_props.fail_cnt;
        $display("summary: %0d sums compared, %0d errors, %0d assertion failures",
                 sum_cnt, err_cnt, assert_cnt);
        if (err_cnt == 0 && assert_cnt == 0)
            $display("Finished with no errors");
        else
            $display("Finished with errors");
        $finish;
    end

    initial
    begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("timeout: the run was still going after %0d cycles", WATCHDOG_CYCLES);
        $display("Finished with errors");
        $finish;
    end

endmodule

`default_nettype wire

/* list.f */
verilog/boxcar_pkg.sv
verilog/sdp_ram.sv
verilog/ram_shift_reg.sv
verilog/moving_sum.sv
verilog/apb_ctrl_regs.sv
verilog/boxcar_top.sv
verif/boxcar_props.sv
verif/boxcar_checker.sv
verif/boxcar_tb.sv
